// ==== design/rvCfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Byte address width of the instruction and data ports.
`define AddrWidth 32

// Width of a register and of a memory word.
`define DataWidth 32

// Data memory depth in words.
`define MemWords 256

`endif

// ==== design/rvPkg.sv ====
package rvPkg;

// Instruction class, chosen by the decoder and consumed by the controller.
typedef enum logic [2:0]
{
	Idle,
	RegWrite,
	MemReadRegWrite,
	MemWrite,
	PCSelectWrite,
	PCWrite,
	LuiRegWrite
} stateT;

// The ten arithmetic operations followed by the six branch tests.
typedef enum logic [3:0]
{
	AluAdd,
	AluSub,
	AluSll,
	AluSlt,
	AluSltu,
	AluXor,
	AluSrl,
	AluSra,
	AluOr,
	AluAnd,
	AluEq,
	AluNe,
	AluLt,
	AluGe,
	AluLtu,
	AluGeu
} aluOpT;

// One instruction word seen through each RV32I format.
typedef union packed
{
	struct packed
	{
		logic	[6:0]	funct7;
		logic	[4:0]	rs2;
		logic	[4:0]	rs1;
		logic	[2:0]	func3;
		logic	[4:0]	rd;
		logic	[6:0]	opcode;
	} r;
	struct packed
	{
		logic	[11:0]	imm;
		logic	[4:0]	rs1;
		logic	[2:0]	func3;
		logic	[4:0]	rd;
		logic	[6:0]	opcode;
	} i;
	struct packed
	{
		logic	[6:0]	immHi;
		logic	[4:0]	rs2;
		logic	[4:0]	rs1;
		logic	[2:0]	func3;
		logic	[4:0]	immLo;
		logic	[6:0]	opcode;
	} s;
	struct packed
	{
		logic			imm12;
		logic	[5:0]	imm10to5;
		logic	[4:0]	rs2;
		logic	[4:0]	rs1;
		logic	[2:0]	func3;
		logic	[3:0]	imm4to1;
		logic			imm11;
		logic	[6:0]	opcode;
	} b;
	struct packed
	{
		logic	[19:0]	imm;
		logic	[4:0]	rd;
		logic	[6:0]	opcode;
	} u;
	struct packed
	{
		logic			imm20;
		logic	[9:0]	imm10to1;
		logic			imm11;
		logic	[7:0]	imm19to12;
		logic	[4:0]	rd;
		logic	[6:0]	opcode;
	} j;
} instrU;

endpackage

// ==== design/DataMem.sv ====
`timescale 1ns/1ps
`include "rvCfg.svh"

module DataMem (
	input	logic					clk,
	input	logic					memWriteEnable,
	input	logic	[2:0]			func3,
	input	logic	[`AddrWidth-1:0]	memAddr,
	input	logic	[`DataWidth-1:0]	memWriteData,
	output	logic	[`DataWidth-1:0]	memReadData,
	input	logic	[`AddrWidth-1:0]	memWatchAddr,
	output	logic	[`DataWidth-1:0]	memWatchData
);

localparam int IndexWidth = $clog2(`MemWords);
localparam int Lanes = `DataWidth / 8;

logic [`DataWidth-1:0] mem [0:`MemWords-1];
logic [1:0] offset;
logic [Lanes-1:0] laneMask;
logic [`DataWidth-1:0] laneData;
logic [`DataWidth-1:0] readWord;
logic [7:0] loadByte;
logic [15:0] loadHalf;

assign offset = memAddr[1:0];

// Store data is replicated so the addressed lanes see it wherever they sit.
always_comb
begin
	case (func3[1:0])
		2'b00:
		begin
			laneMask = Lanes'(1) << offset;
			laneData = {Lanes{memWriteData[7:0]}};
		end
		2'b01:
		begin
			laneMask = Lanes'(3) << {offset[1], 1'b0};
			laneData = {(Lanes / 2){memWriteData[15:0]}};
		end
		default:
		begin
			laneMask = '1;
			laneData = memWriteData;
		end
	endcase
end

always_ff @(posedge clk)
begin
	if (memWriteEnable)
	begin
		for (int lane = 0; lane < Lanes; lane++)
		begin
			if (laneMask[lane])
				mem[memAddr[IndexWidth+1:2]][8*lane +: 8] <= laneData[8*lane +: 8];
		end
	end
end

assign readWord = mem[memAddr[IndexWidth+1:2]];
assign loadByte = readWord[8*offset +: 8];
assign loadHalf = readWord[16*offset[1] +: 16];

always_comb
begin
	case (func3)
		3'b000: memReadData = {{(`DataWidth-8){loadByte[7]}}, loadByte};
		3'b001: memReadData = {{(`DataWidth-16){loadHalf[15]}}, loadHalf};
		3'b100: memReadData = {{(`DataWidth-8){1'b0}}, loadByte};
		3'b101: memReadData = {{(`DataWidth-16){1'b0}}, loadHalf};
		default: memReadData = readWord;
	endcase
end

assign memWatchData = mem[memWatchAddr[IndexWidth+1:2]];

endmodule

// ==== design/Controller.sv ====
`timescale 1ns/1ps
`include "rvCfg.svh"

module Controller (
	input	logic					clk,
	input	logic					reset,
	input	rvPkg::stateT			state,
	input	logic	[2:0]			func3,
	input	logic	[`AddrWidth-1:0]	pc,
	input	logic	[`DataWidth-1:0]	imm,
	input	logic	[`DataWidth-1:0]	regReadData1,
	input	logic	[`DataWidth-1:0]	aluO,
	output	logic					pcWriteEnable,
	output	logic					regWriteEnable,
	output	logic	[`AddrWidth-1:0]	pcWriteData,
	output	logic	[`DataWidth-1:0]	regWriteData,
	input	logic	[`AddrWidth-1:0]	memWatchAddr,
	output	logic	[`DataWidth-1:0]	memWatchData
);

import rvPkg::*;

logic memWriteEnable;
logic [`AddrWidth-1:0] memAddr;
logic [`DataWidth-1:0] memWriteData;
logic [`DataWidth-1:0] memReadData;

// ####################################################################
// Memory side. Only the write enable depends on the state.
assign memAddr = aluO;
assign memWriteData = regReadData1;
assign memWriteEnable = !reset && state == MemWrite;

// ####################################################################
always_comb
begin
	if (reset)
	begin
		pcWriteEnable = 1'b1;
		pcWriteData = '0;
		regWriteEnable = 1'b0;
		regWriteData = '0;
	end
	else
	begin
		case (state)
			RegWrite:
			begin
				pcWriteEnable = 1'b0;
				pcWriteData = '0;
				regWriteEnable = 1'b1;
				regWriteData = aluO;
			end
			MemReadRegWrite:
			begin
				pcWriteEnable = 1'b0;
				pcWriteData = '0;
				regWriteEnable = 1'b1;
				regWriteData = memReadData;
			end
			MemWrite:
			begin
				pcWriteEnable = 1'b0;
				pcWriteData = '0;
				regWriteEnable = 1'b0;
				regWriteData = '0;
			end
			PCSelectWrite:
			begin
				// The ALU flag says whether the branch is taken.
				pcWriteEnable = aluO[0];
				pcWriteData = pc + imm;
				regWriteEnable = 1'b0;
				regWriteData = '0;
			end
			PCWrite:
			begin
				// jalr clears the lowest target bit
				pcWriteEnable = 1'b1;
				pcWriteData = {aluO[`AddrWidth-1:1], 1'b0};
				regWriteEnable = 1'b1;
				regWriteData = pc + 4;
			end
			LuiRegWrite:
			begin
				pcWriteEnable = 1'b0;
				pcWriteData = '0;
				regWriteEnable = 1'b1;
				regWriteData = imm;
			end
			default:
			begin
				// Idle and unused codes just fall through to pc plus 4.
				pcWriteEnable = 1'b0;
				pcWriteData = '0;
				regWriteEnable = 1'b0;
				regWriteData = '0;
			end
		endcase
	end
end

DataMem mem (
	.clk			(clk),
	.memWriteEnable	(memWriteEnable),
	.func3			(func3),
	.memAddr		(memAddr),
	.memWriteData	(memWriteData),
	.memReadData	(memReadData),
	.memWatchAddr	(memWatchAddr),
	.memWatchData	(memWatchData)
);

// ####################################################################
// A store and a register write never share an edge.
assert property (@(posedge clk) disable iff (reset) memWriteEnable |-> !regWriteEnable);

// The pc register in the core takes the redirect and stays word aligned.
assert property (@(posedge clk) disable iff (reset)
	pcWriteEnable |=> pc == $past(pcWriteData) && pc[1:0] == 2'b00);

endmodule

// ==== design/Decoder.sv ====
`timescale 1ns/1ps
`include "rvCfg.svh"

module Decoder (
	input	logic	[`DataWidth-1:0]	instr,
	output	rvPkg::stateT			state,
	output	rvPkg::aluOpT			aluOp,
	output	logic					useImm,
	output	logic	[`DataWidth-1:0]	imm,
	output	logic	[2:0]			func3,
	output	logic	[4:0]			rs1,
	output	logic	[4:0]			rs2,
	output	logic	[4:0]			rd
);

import rvPkg::*;

localparam logic [6:0] OpReg = 7'b0110011;
localparam logic [6:0] OpImm = 7'b0010011;
localparam logic [6:0] OpLui = 7'b0110111;
localparam logic [6:0] OpLoad = 7'b0000011;
localparam logic [6:0] OpStore = 7'b0100011;
localparam logic [6:0] OpBranch = 7'b1100011;
localparam logic [6:0] OpJal = 7'b1101111;
localparam logic [6:0] OpJalr = 7'b1100111;

instrU word;
logic [`DataWidth-1:0] iImm;
logic [`DataWidth-1:0] sImm;
logic [`DataWidth-1:0] bImm;
logic [`DataWidth-1:0] uImm;
logic [`DataWidth-1:0] jImm;

// Bit 30 picks sub over add and sra over srl.
function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
	case (f3)
		3'b000: return alt ? AluSub : AluAdd;
		3'b001: return AluSll;
		3'b010: return AluSlt;
		3'b011: return AluSltu;
		3'b100: return AluXor;
		3'b101: return alt ? AluSra : AluSrl;
		3'b110: return AluOr;
		default: return AluAnd;
	endcase
endfunction

assign word = instr;
assign func3 = word.r.func3;
assign rs1 = word.r.rs1;
assign rs2 = word.r.rs2;
assign rd = word.r.rd;

// ####################################################################
// Immediates, sign extended from each format.
assign iImm = {{(`DataWidth-12){word.i.imm[11]}}, word.i.imm};
assign sImm = {{(`DataWidth-12){word.s.immHi[6]}}, word.s.immHi, word.s.immLo};
assign bImm = {{(`DataWidth-13){word.b.imm12}}, word.b.imm12, word.b.imm11,
	word.b.imm10to5, word.b.imm4to1, 1'b0};
assign uImm = {word.u.imm, 12'b0};
assign jImm = {{(`DataWidth-21){word.j.imm20}}, word.j.imm20, word.j.imm19to12,
	word.j.imm11, word.j.imm10to1, 1'b0};

// ####################################################################
always_comb
begin
	state = Idle;
	aluOp = AluAdd;
	useImm = 1'b0;
	imm = '0;
	case (word.r.opcode)
		OpReg:
		begin
			state = RegWrite;
			aluOp = arithOp(word.r.func3, word.r.funct7[5]);
		end
		OpImm:
		begin
			state = RegWrite;
			aluOp = arithOp(word.i.func3, word.i.func3 == 3'b101 && word.i.imm[10]);
			useImm = 1'b1;
			imm = iImm;
		end
		OpLui:
		begin
			state = LuiRegWrite;
			imm = uImm;
		end
		OpLoad:
		begin
			state = MemReadRegWrite;
			useImm = 1'b1;
			imm = iImm;
		end
		OpStore:
		begin
			state = MemWrite;
			useImm = 1'b1;
			imm = sImm;
		end
		OpBranch:
		begin
			state = PCSelectWrite;
			imm = bImm;
			case (word.b.func3)
				3'b000: aluOp = AluEq;
				3'b001: aluOp = AluNe;
				3'b100: aluOp = AluLt;
				3'b101: aluOp = AluGe;
				3'b110: aluOp = AluLtu;
				3'b111: aluOp = AluGeu;
				default: state = Idle;
			endcase
		end
		OpJal:
		begin
			state = PCWrite;
			useImm = 1'b1;
			imm = jImm;
		end
		OpJalr:
		begin
			state = PCWrite;
			useImm = 1'b1;
			imm = iImm;
		end
		default:
			state = Idle;
	endcase
end

endmodule

// ==== design/RegFile.sv ====
`timescale 1ns/1ps
`include "rvCfg.svh"

module RegFile (
	input	logic					clk,
	input	logic					reset,
	input	logic	[4:0]			rs1,
	input	logic	[4:0]			rs2,
	input	logic	[4:0]			rd,
	input	logic					regWriteEnable,
	input	logic	[`DataWidth-1:0]	regWriteData,
	output	logic	[`DataWidth-1:0]	rsData1,
	output	logic	[`DataWidth-1:0]	rsData2
);

// x0 is cleared by reset like the others and then never written.
logic [`DataWidth-1:0] regs [0:31];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int idx = 0; idx < 32; idx++)
			regs[idx] <= '0;
	end
	else if (regWriteEnable && rd != '0)
		regs[rd] <= regWriteData;
end

assign rsData1 = regs[rs1];
assign rsData2 = regs[rs2];

// Both read ports see zero whenever they address x0.
assert property (@(posedge clk) disable iff (reset)
	(rs1 != '0 || rsData1 == '0) && (rs2 != '0 || rsData2 == '0));

endmodule

// ==== design/Alu.sv ====
`timescale 1ns/1ps
`include "rvCfg.svh"

module Alu (
	input	rvPkg::aluOpT			aluOp,
	input	logic	[`DataWidth-1:0]	a,
	input	logic	[`DataWidth-1:0]	b,
	output	logic	[`DataWidth-1:0]	aluO
);

import rvPkg::*;

localparam int ShiftWidth = $clog2(`DataWidth);

logic [ShiftWidth-1:0] shamt;
logic signed [`DataWidth-1:0] aSigned;
logic signed [`DataWidth-1:0] bSigned;

assign shamt = b[ShiftWidth-1:0];
assign aSigned = a;
assign bSigned = b;

always_comb
begin
	aluO = '0;
	case (aluOp)
		AluAdd: aluO = a + b;
		AluSub: aluO = a - b;
		AluSll: aluO = a << shamt;
		AluSlt: aluO[0] = aSigned < bSigned;
		AluSltu: aluO[0] = a < b;
		AluXor: aluO = a ^ b;
		AluSrl: aluO = a >> shamt;
		AluSra: aluO = aSigned >>> shamt;
		AluOr: aluO = a | b;
		AluAnd: aluO = a & b;
		// Branch tests leave a single flag in bit 0.
		AluEq: aluO[0] = a == b;
		AluNe: aluO[0] = a != b;
		AluLt: aluO[0] = aSigned < bSigned;
		AluGe: aluO[0] = aSigned >= bSigned;
		AluLtu: aluO[0] = a < b;
		AluGeu: aluO[0] = a >= b;
		default: aluO = '0;
	endcase
end

endmodule

// ==== design/Core.sv ====
`timescale 1ns/1ps
`include "rvCfg.svh"

module Core (
	input	logic					clk,
	input	logic					reset,
	output	logic	[`AddrWidth-1:0]	instrAddr,
	input	logic	[`DataWidth-1:0]	instr,
	input	logic	[`AddrWidth-1:0]	memWatchAddr,
	output	logic	[`DataWidth-1:0]	memWatchData
);

import rvPkg::*;

localparam logic [6:0] OpJal = 7'b1101111;

logic [`AddrWidth-1:0] pc;
stateT state;
aluOpT aluOp;
logic useImm;
logic [`DataWidth-1:0] imm;
logic [2:0] func3;
logic [4:0] rs1;
logic [4:0] rs2;
logic [4:0] rd;
logic [`DataWidth-1:0] rsData1;
logic [`DataWidth-1:0] rsData2;
logic isJal;
logic [`DataWidth-1:0] aluA;
logic [`DataWidth-1:0] aluB;
logic [`DataWidth-1:0] aluO;
logic regWriteEnable;
logic [`DataWidth-1:0] regWriteData;
logic pcWriteEnable;
logic [`AddrWidth-1:0] pcWriteData;

// ####################################################################
// Program counter. Every clock retires one instruction.
always_ff @(posedge clk)
begin
	if (reset)
		pc <= '0;
	else if (pcWriteEnable)
		pc <= pcWriteData;
	else
		pc <= pc + 4;
end

assign instrAddr = pc;

// jal is the one jump whose base is the pc rather than rs1.
assign isJal = instr[6:0] == OpJal;
assign aluA = isJal ? pc : rsData1;
assign aluB = useImm ? imm : rsData2;

// ####################################################################
Decoder decoder (
	.instr	(instr),
	.state	(state),
	.aluOp	(aluOp),
	.useImm	(useImm),
	.imm	(imm),
	.func3	(func3),
	.rs1	(rs1),
	.rs2	(rs2),
	.rd		(rd)
);

RegFile regFile (
	.clk			(clk),
	.reset			(reset),
	.rs1			(rs1),
	.rs2			(rs2),
	.rd				(rd),
	.regWriteEnable	(regWriteEnable),
	.regWriteData	(regWriteData),
	.rsData1		(rsData1),
	.rsData2		(rsData2)
);

Alu alu (
	.aluOp	(aluOp),
	.a		(aluA),
	.b		(aluB),
	.aluO	(aluO)
);

Controller controller (
	.clk			(clk),
	.reset			(reset),
	.state			(state),
	.func3			(func3),
	.pc				(pc),
	.imm			(imm),
	.regReadData1	(rsData2),
	.aluO			(aluO),
	.pcWriteEnable	(pcWriteEnable),
	.regWriteEnable	(regWriteEnable),
	.pcWriteData	(pcWriteData),
	.regWriteData	(regWriteData),
	.memWatchAddr	(memWatchAddr),
	.memWatchData	(memWatchData)
);

endmodule

// ==== tests/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [6:0] OpcReg = 7'b0110011;
localparam logic [6:0] OpcImm = 7'b0010011;
localparam logic [6:0] OpcLui = 7'b0110111;
localparam logic [6:0] OpcLoad = 7'b0000011;
localparam logic [6:0] OpcStore = 7'b0100011;
localparam logic [6:0] OpcBranch = 7'b1100011;
localparam logic [6:0] OpcJal = 7'b1101111;
localparam logic [6:0] OpcJalr = 7'b1100111;

// ######################################################################
// Instruction encoders, filled field by field through the format union.

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	instrU w;
	w.r.funct7 = f7;
	w.r.rs2 = rs2;
	w.r.rs1 = rs1;
	w.r.func3 = f3;
	w.r.rd = rd;
	w.r.opcode = OpcReg;
	return w;
endfunction

function automatic logic [31:0] encI(input logic [6:0] op, input logic [4:0] rd,
	input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm);
	instrU w;
	w.i.imm = imm;
	w.i.rs1 = rs1;
	w.i.func3 = f3;
	w.i.rd = rd;
	w.i.opcode = op;
	return w;
endfunction

function automatic logic [31:0] encS(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [11:0] imm);
	instrU w;
	w.s.immHi = imm[11:5];
	w.s.rs2 = rs2;
	w.s.rs1 = rs1;
	w.s.func3 = f3;
	w.s.immLo = imm[4:0];
	w.s.opcode = OpcStore;
	return w;
endfunction

function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] off);
	instrU w;
	w.b.imm12 = off[12];
	w.b.imm10to5 = off[10:5];
	w.b.rs2 = rs2;
	w.b.rs1 = rs1;
	w.b.func3 = f3;
	w.b.imm4to1 = off[4:1];
	w.b.imm11 = off[11];
	w.b.opcode = OpcBranch;
	return w;
endfunction

function automatic logic [31:0] encU(input logic [4:0] rd, input logic [19:0] imm);
	instrU w;
	w.u.imm = imm;
	w.u.rd = rd;
	w.u.opcode = OpcLui;
	return w;
endfunction

function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
	instrU w;
	w.j.imm20 = off[20];
	w.j.imm10to1 = off[10:1];
	w.j.imm11 = off[11];
	w.j.imm19to12 = off[19:12];
	w.j.rd = rd;
	w.j.opcode = OpcJal;
	return w;
endfunction

// ######################################################################
// Expected results, straight from the RV32I definitions.

function automatic logic [31:0] refArith(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	logic [31:0] res;
	sa = a;
	sb = b;
	case (f3)
		3'b000: res = alt ? a - b : a + b;
		3'b001: res = a << b[4:0];
		3'b010: res = {31'b0, sa < sb};
		3'b011: res = {31'b0, a < b};
		3'b100: res = a ^ b;
		3'b101:
		begin
			if (alt)
				res = sa >>> b[4:0];
			else
				res = a >> b[4:0];
		end
		3'b110: res = a | b;
		default: res = a & b;
	endcase
	return res;
endfunction

function automatic logic branchCond(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	sa = a;
	sb = b;
	case (f3)
		3'b000: return a == b;
		3'b001: return a != b;
		3'b100: return sa < sb;
		3'b101: return sa >= sb;
		3'b110: return a < b;
		default: return a >= b;
	endcase
endfunction

function automatic logic [31:0] pcOf(input logic [6:0] idx);
	return {23'b0, idx, 2'b00};
endfunction

// ######################################################################
// Program assembly.

task automatic emit(input logic [31:0] word);
	prog[emitIdx] = word;
	emitIdx++;
endtask

task automatic addExpect(input logic [31:0] addr, input logic [31:0] data);
	expAddr.push_back(addr);
	expData.push_back(data);
endtask

// Stores a register into the next result slot.
task automatic storeResult(input logic [4:0] rs, input logic [31:0] value);
	emit(encS(3'b010, 5'd0, rs, resultAddr[11:0]));
	addExpect(resultAddr, value);
	resultAddr += 32'd4;
endtask

// The extra 0x800 makes up for addi sign extending its low 12 bits.
task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
	logic [31:0] upper;
	upper = value + 32'h800;
	emit(encU(rd, upper[31:12]));
	emit(encI(OpcImm, rd, 3'b000, rd, value[11:0]));
endtask

task automatic arithCase(input logic [2:0] f3, input logic alt, input logic useImm,
	input logic [31:0] a, input logic [31:0] regB);
	logic [31:0] rnd;
	logic [11:0] imm;
	logic [31:0] b;
	rnd = $random(seed);
	imm = rnd[11:0];
	if (f3 == 3'b001 || f3 == 3'b101)
		imm = {1'b0, alt, 5'b0, rnd[4:0]};
	b = useImm ? {{20{imm[11]}}, imm} : regB;
	if (useImm)
		emit(encI(OpcImm, 5'd10, f3, 5'd1, imm));
	else
		emit(encR(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, 5'd10));
	storeResult(5'd10, refArith(f3, alt, a, b));
endtask

task automatic loadCase(input logic [2:0] f3, input logic [11:0] addr,
	input logic [31:0] value);
	emit(encI(OpcLoad, 5'd12, f3, 5'd0, addr));
	storeResult(5'd12, value);
endtask

// A branch skips the counter increment behind it when taken.
task automatic branchCase(input logic [2:0] f3, input logic [4:0] rsA, input logic [4:0] rsB,
	input logic [31:0] a, input logic [31:0] b, inout logic [31:0] count);
	logic taken;
	taken = branchCond(f3, a, b);
	branchTaken[emitIdx] = taken;
	emit(encB(f3, rsA, rsB, 13'd8));
	emit(encI(OpcImm, 5'd14, 3'b000, 5'd14, 12'd1));
	if (!taken)
		count++;
endtask

`endif

// ==== tests/CoreTb.sv ====
`timescale 1ns/1ps

module CoreTb;

import rvPkg::*;

localparam int MaxCycles = 400;

logic clk;
logic reset;
logic [31:0] instrAddr;
logic [31:0] instr;
logic [31:0] memWatchAddr;
logic [31:0] memWatchData;

int seed = 8882;
logic [31:0] prog [0:127];
logic branchTaken [0:127];
logic [31:0] jumpTarget [0:127];
logic [6:0] emitIdx;
logic [31:0] resultAddr;
logic [31:0] finalAddr;
logic [31:0] expAddr [$];
logic [31:0] expData [$];

instrU fetched;
logic [31:0] bImm;
logic isBranch;
logic isJump;
logic [31:0] flowNext;

`include "tbProgram.svh"

task automatic checkFail(input string msg);
	$display("CHECK FAILED at %0t: %s", $time, msg);
	$display("TB FAILED");
	$fatal(1, "stopped at the first failing check");
endtask

task automatic abortRun(input string msg);
	$display("%s", msg);
	$display("TB FAILED");
	$fatal(1, "run aborted");
endtask

task automatic buildProgram();
	logic [31:0] val1;
	logic [31:0] val2;
	logic [31:0] val3;
	logic [31:0] rnd;
	logic [31:0] lane;
	logic [31:0] target;
	logic [31:0] skipped;
	prog = '{default: '0};
	branchTaken = '{default: 1'b0};
	jumpTarget = '{default: '0};
	emitIdx = '0;
	resultAddr = '0;
	skipped = '0;
	val1 = $random(seed);
	val2 = $random(seed);
	val3 = $random(seed);
	// Fix the sign bits so the loads see both extensions.
	val1[7] = 1'b0;
	val2[7] = 1'b1;
	val3[15] = 1'b0;
	loadConst(5'd1, val1);
	loadConst(5'd2, val2);
	loadConst(5'd3, val3);
	for (int f = 0; f < 8; f++)
		arithCase(3'(f), 1'b0, 1'b0, val1, val2);
	arithCase(3'b000, 1'b1, 1'b0, val1, val2);
	arithCase(3'b101, 1'b1, 1'b0, val1, val2);
	for (int f = 0; f < 8; f++)
		arithCase(3'(f), 1'b0, 1'b1, val1, val2);
	arithCase(3'b101, 1'b1, 1'b1, val1, val2);
	rnd = $random(seed);
	emit(encU(5'd11, rnd[31:12]));
	storeResult(5'd11, {rnd[31:12], 12'b0});
	// Word, byte and halfword stores into one word, then every load width.
	emit(encS(3'b010, 5'd0, 5'd1, 12'h200));
	emit(encS(3'b000, 5'd0, 5'd2, 12'h201));
	emit(encS(3'b001, 5'd0, 5'd3, 12'h202));
	lane = {val3[15:0], val2[7:0], val1[7:0]};
	addExpect(32'h200, lane);
	loadCase(3'b000, 12'h200, {{24{lane[7]}}, lane[7:0]});
	loadCase(3'b000, 12'h201, {{24{lane[15]}}, lane[15:8]});
	loadCase(3'b100, 12'h201, {24'b0, lane[15:8]});
	loadCase(3'b001, 12'h200, {{16{lane[15]}}, lane[15:0]});
	loadCase(3'b101, 12'h200, {16'b0, lane[15:0]});
	loadCase(3'b001, 12'h202, {{16{lane[31]}}, lane[31:16]});
	loadCase(3'b100, 12'h203, {24'b0, lane[31:24]});
	for (int f = 0; f < 8; f++)
	begin
		if (f != 2 && f != 3)
		begin
			branchCase(3'(f), 5'd1, 5'd1, val1, val1, skipped);
			branchCase(3'(f), 5'd1, 5'd2, val1, val2, skipped);
			branchCase(3'(f), 5'd2, 5'd1, val2, val1, skipped);
		end
	end
	storeResult(5'd14, skipped);
	// jal over one increment, then jalr through a base register.
	jumpTarget[emitIdx] = pcOf(emitIdx) + 32'd8;
	target = pcOf(emitIdx) + 32'd4;
	emit(encJ(5'd5, 21'd8));
	emit(encI(OpcImm, 5'd15, 3'b000, 5'd15, 12'd1));
	storeResult(5'd5, target);
	target = pcOf(emitIdx + 7'd3);
	emit(encI(OpcImm, 5'd6, 3'b000, 5'd0, target[11:0] - 12'd4));
	jumpTarget[emitIdx] = target;
	target = pcOf(emitIdx) + 32'd4;
	emit(encI(OpcJalr, 5'd7, 3'b000, 5'd6, 12'd4));
	emit(encI(OpcImm, 5'd15, 3'b000, 5'd15, 12'd1));
	storeResult(5'd7, target);
	storeResult(5'd15, 32'd0);
	finalAddr = pcOf(emitIdx);
	jumpTarget[emitIdx] = finalAddr;
	emit(encJ(5'd0, 21'd0));
endtask

Core DUT (
	.clk			(clk),
	.reset			(reset),
	.instrAddr		(instrAddr),
	.instr			(instr),
	.memWatchAddr	(memWatchAddr),
	.memWatchData	(memWatchData)
);

always #20 clk = ~clk;

// Instruction memory answers in the same cycle.
assign instr = prog[instrAddr[8:2]];

// ######################################################################
// Own decoding of the fetched word, for the pc checks.
assign fetched = instr;
assign bImm = {{19{fetched.b.imm12}}, fetched.b.imm12, fetched.b.imm11,
	fetched.b.imm10to5, fetched.b.imm4to1, 1'b0};
assign isBranch = fetched.r.opcode == OpcBranch;
assign isJump = fetched.r.opcode == OpcJal || fetched.r.opcode == OpcJalr;

always_comb
begin
	if (isBranch)
		flowNext = branchTaken[instrAddr[8:2]] ? instrAddr + bImm : instrAddr + 32'd4;
	else if (isJump)
		flowNext = jumpTarget[instrAddr[8:2]];
	else
		flowNext = instrAddr + 32'd4;
end

assert property (@(posedge clk) $fell(reset) |-> instrAddr == '0)
	else checkFail("first fetch after reset is not at address 0");

assert property (@(posedge clk) disable iff (reset)
	!isBranch && !isJump |=> instrAddr == $past(instrAddr) + 32'd4)
	else checkFail($sformatf("pc went to %h instead of stepping by 4", instrAddr));

assert property (@(posedge clk) disable iff (reset)
	isBranch |=> instrAddr == $past(flowNext))
	else checkFail($sformatf("branch continued at wrong address %h", instrAddr));

assert property (@(posedge clk) disable iff (reset)
	isJump |=> instrAddr == $past(flowNext))
	else checkFail($sformatf("jump landed on wrong address %h", instrAddr));

// ######################################################################
initial
begin
	int cycles;
	clk = 1'b0;
	reset = 1'b1;
	memWatchAddr = '0;
	buildProgram();
	repeat (16) @(negedge clk);
	reset = 1'b0;

	cycles = 0;
	while (instrAddr !== finalAddr)
	begin
		if (cycles == MaxCycles)
			abortRun("The program never reached its final loop before the cycle limit.");
		else
		begin
			@(negedge clk);
			cycles++;
		end
	end

	// Results are read back through the watch port, one word per cycle.
	foreach (expAddr[k])
	begin
		memWatchAddr = expAddr[k];
		@(negedge clk);
		assert (memWatchData == expData[k])
			else checkFail($sformatf("word at %h is %h, expected %h",
				expAddr[k], memWatchData, expData[k]));
	end

	$display("TB PASSED");
	$finish;
end

endmodule

// ==== all.f ====
+incdir+design
+incdir+tests
design/rvPkg.sv
design/DataMem.sv
design/Controller.sv
design/Decoder.sv
design/RegFile.sv
design/Alu.sv
design/Core.sv
tests/CoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= CoreTb
OBJ_DIR ?= obj_dir
FILELIST ?= all.f
VFLAGS ?= --binary --assert --timing -j 0

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv tests/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits with a failing status when the testbench stops on an error.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
